/* common/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// width of client data and byte addresses.
`define MEM_DATA_W 32

// number of clients sharing the port.
`define MEM_CLIENTS 2

// RAM depth in words. Addresses beyond it wrap.
`define MEM_DEPTH_WORDS 256

`define MEM_BYTES 4 // byte lanes per RAM word.

`endif

/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // access width as a client encodes it on the widths bus.
    typedef enum logic [1:0] {
        ACC_8  = 2'b00,
        ACC_16 = 2'b01,
        ACC_32 = 2'b10
    } mem_width_e;

    // phases of the access engine. A split access visits the HI pair first.
    typedef enum logic [2:0] {
        PH_IDLE = 3'd0,
        PH_HI_1 = 3'd1,
        PH_HI_2 = 3'd2,
        PH_LO_1 = 3'd3,
        PH_LO_2 = 3'd4,
        PH_DONE = 3'd5
    } mem_phase_e;

endpackage

`default_nettype wire

/* hdl/byte_ram.sv */
`default_nettype none
`include "mem_consts.svh"

module byte_ram (
    input  wire                                   clk,
    input  wire [$clog2(`MEM_DEPTH_WORDS)-1:0]    addr,
    input  wire [`MEM_DATA_W-1:0]                 wdata,
    input  wire [`MEM_BYTES-1:0]                  be,
    output logic [`MEM_DATA_W-1:0]                rdata
);

    logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH_WORDS];

    // the read returns the word as it was before this cycle's write.
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MEM_BYTES; i++) begin
            if (be[i]) begin
                mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* mem_if/mem_arbiter.sv */
`default_nettype none
`include "mem_consts.svh"

module mem_arbiter (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire [`MEM_CLIENTS-1:0]                requests,
    input  wire [`MEM_CLIENTS*`MEM_DATA_W-1:0]    addrs,
    input  wire [`MEM_CLIENTS-1:0]                wes,
    input  wire [2*`MEM_CLIENTS-1:0]              widths,
    input  wire [`MEM_CLIENTS*`MEM_DATA_W-1:0]    wdata,
    input  wire                                   eng_ready,
    input  wire [`MEM_DATA_W-1:0]                 eng_rdata,
    output logic [`MEM_CLIENTS-1:0]               readies,
    output logic [`MEM_CLIENTS*`MEM_DATA_W-1:0]   rdata,
    output logic                                  eng_request,
    output logic [`MEM_DATA_W-1:0]                eng_addr,
    output logic                                  eng_we,
    output mem_pkg::mem_width_e                   eng_width,
    output logic [`MEM_DATA_W-1:0]                eng_wdata
);
    import mem_pkg::*;

    localparam int IDX_W = (`MEM_CLIENTS > 1) ? $clog2(`MEM_CLIENTS) : 1;

    logic             busy_q;
    logic [IDX_W-1:0] grant_q;
    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] next_sel;
    logic [IDX_W-1:0] sel;

    // the nearest requester after the last one served wins.
    always_comb begin
        int cand;
        next_sel = last_q;
        for (int k = `MEM_CLIENTS; k >= 1; k--) begin
            cand = (int'(last_q) + k) % `MEM_CLIENTS;
            if (requests[cand]) begin
                next_sel = IDX_W'(cand);
            end
        end
    end

    assign sel = busy_q ? grant_q : next_sel; // locked while an access is in flight.

    assign eng_request = requests[sel];
    assign eng_addr    = addrs[sel*`MEM_DATA_W +: `MEM_DATA_W];
    assign eng_we      = wes[sel];
    assign eng_width   = mem_width_e'(widths[2*sel +: 2]);
    assign eng_wdata   = wdata[sel*`MEM_DATA_W +: `MEM_DATA_W];

    // only the granted client sees the engine's response.
    always_comb begin
        for (int i = 0; i < `MEM_CLIENTS; i++) begin
            readies[i] = busy_q && (grant_q == IDX_W'(i)) && eng_ready;
            rdata[i*`MEM_DATA_W +: `MEM_DATA_W] =
                (busy_q && (grant_q == IDX_W'(i))) ? eng_rdata : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            grant_q <= '0;
            last_q  <= IDX_W'(`MEM_CLIENTS - 1); // so client 0 is served first.
        end else if (busy_q) begin
            if (eng_ready) begin
                busy_q <= 1'b0;
                last_q <= grant_q;
            end
        end else if (requests[next_sel]) begin
            busy_q  <= 1'b1;
            grant_q <= next_sel;
        end
    end

endmodule

`default_nettype wire

/* mem_if/mem_if.sv */
`default_nettype none
`include "mem_consts.svh"

module mem_if (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   eng_request,
    input  wire [`MEM_DATA_W-1:0]                 eng_addr,
    input  wire                                   eng_we,
    input  wire mem_pkg::mem_width_e              eng_width,
    input  wire [`MEM_DATA_W-1:0]                 eng_wdata,
    input  wire [`MEM_DATA_W-1:0]                 ram_rdata,
    output logic                                  eng_ready,
    output logic [`MEM_DATA_W-1:0]                eng_rdata,
    output logic [$clog2(`MEM_DEPTH_WORDS)-1:0]   ram_addr,
    output logic [`MEM_DATA_W-1:0]                ram_wdata,
    output logic [`MEM_BYTES-1:0]                 ram_be
);
    import mem_pkg::*;

    localparam int OFF_W   = $clog2(`MEM_BYTES);
    localparam int WADDR_W = $clog2(`MEM_DEPTH_WORDS);

    mem_phase_e             phase_q;
    logic [OFF_W-1:0]       lo_shift;
    logic [OFF_W-1:0]       hi_shift;
    logic [WADDR_W-1:0]     lo_word;
    logic [`MEM_BYTES-1:0]  width_be;
    logic [`MEM_DATA_W-1:0] width_mask;
    logic                   single;
    logic [`MEM_DATA_W-1:0] hi_q;
    logic [`MEM_DATA_W-1:0] lo_part;
    logic [`MEM_DATA_W-1:0] hi_part;

    assign lo_shift = eng_addr[OFF_W-1:0];
    assign lo_word  = eng_addr[OFF_W +: WADDR_W]; // upper address bits wrap away.

    // the high word holds the bytes that spill past the end of the low word.
    assign hi_shift = OFF_W'(`MEM_BYTES - lo_shift);

    always_comb begin
        case (eng_width)
            ACC_8:   width_be = `MEM_BYTES'('b0001);
            ACC_16:  width_be = `MEM_BYTES'('b0011);
            default: width_be = '1;
        endcase
    end

    always_comb begin
        for (int i = 0; i < `MEM_BYTES; i++) begin
            width_mask[8*i +: 8] = {8{width_be[i]}};
        end
    end

    // Accesses that fit inside one word need only the LO pair.
    assign single = (eng_width == ACC_8)
                 || (eng_width == ACC_16 && lo_shift != OFF_W'(`MEM_BYTES - 1))
                 || (eng_width == ACC_32 && lo_shift == '0);

    always_comb begin
        ram_addr  = lo_word;
        ram_wdata = eng_wdata << (8 * lo_shift);
        ram_be    = '0;
        case (phase_q)
            PH_HI_1, PH_HI_2: begin
                ram_addr  = lo_word + 1'b1;
                ram_wdata = eng_wdata >> (8 * hi_shift);
                if (phase_q == PH_HI_1 && eng_we) begin
                    ram_be = width_be >> hi_shift;
                end
            end
            PH_LO_1: begin
                if (eng_we) begin
                    ram_be = width_be << lo_shift; // lanes past the word end drop out.
                end
            end
            default: begin
                ram_be = '0;
            end
        endcase
    end

    // high-word bytes wait here until the low word arrives.
    always_ff @(posedge clk) begin
        if (phase_q == PH_IDLE) begin
            hi_q <= '0;
        end else if (phase_q == PH_HI_2) begin
            hi_q <= ram_rdata;
        end
    end

    assign lo_part   = ram_rdata >> (8 * lo_shift);
    assign hi_part   = hi_q << (8 * hi_shift);
    assign eng_rdata = (lo_part | hi_part) & width_mask;
    assign eng_ready = (phase_q == PH_LO_2);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= PH_IDLE;
        end else begin
            case (phase_q)
                PH_IDLE: begin
                    if (eng_request) begin
                        if (single) begin
                            phase_q <= PH_LO_1;
                        end else begin
                            phase_q <= PH_HI_1;
                        end
                    end
                end
                PH_HI_1: phase_q <= PH_HI_2;
                PH_HI_2: phase_q <= PH_LO_1;
                PH_LO_1: phase_q <= PH_LO_2;
                PH_LO_2: phase_q <= PH_DONE;
                default: phase_q <= PH_IDLE; // the done cycle lets the arbiter regrant.
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_subsys.sv */
`default_nettype none
`include "mem_consts.svh"

module mem_subsys (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire [`MEM_CLIENTS-1:0]                requests,
    input  wire [`MEM_CLIENTS*`MEM_DATA_W-1:0]    addrs,
    input  wire [`MEM_CLIENTS-1:0]                wes,
    input  wire [2*`MEM_CLIENTS-1:0]              widths,
    input  wire [`MEM_CLIENTS*`MEM_DATA_W-1:0]    wdata,
    output logic [`MEM_CLIENTS*`MEM_DATA_W-1:0]   rdata,
    output logic [`MEM_CLIENTS-1:0]               readies
);
    import mem_pkg::*;

    logic                                eng_request;
    logic [`MEM_DATA_W-1:0]              eng_addr;
    logic                                eng_we;
    mem_width_e                          eng_width;
    logic [`MEM_DATA_W-1:0]              eng_wdata;
    logic                                eng_ready;
    logic [`MEM_DATA_W-1:0]              eng_rdata;
    logic [$clog2(`MEM_DEPTH_WORDS)-1:0] ram_addr;
    logic [`MEM_DATA_W-1:0]              ram_wdata;
    logic [`MEM_BYTES-1:0]               ram_be;
    logic [`MEM_DATA_W-1:0]              ram_rdata;

    mem_arbiter arbiter_inst (
        .clk         (clk),
        .rst         (rst),
        .requests    (requests),
        .addrs       (addrs),
        .wes         (wes),
        .widths      (widths),
        .wdata       (wdata),
        .eng_ready   (eng_ready),
        .eng_rdata   (eng_rdata),
        .readies     (readies),
        .rdata       (rdata),
        .eng_request (eng_request),
        .eng_addr    (eng_addr),
        .eng_we      (eng_we),
        .eng_width   (eng_width),
        .eng_wdata   (eng_wdata)
    );

    mem_if engine_inst (
        .clk         (clk),
        .rst         (rst),
        .eng_request (eng_request),
        .eng_addr    (eng_addr),
        .eng_we      (eng_we),
        .eng_width   (eng_width),
        .eng_wdata   (eng_wdata),
        .ram_rdata   (ram_rdata),
        .eng_ready   (eng_ready),
        .eng_rdata   (eng_rdata),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_be      (ram_be)
    );

    byte_ram ram_inst (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .be    (ram_be),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* bench/tb_mem_subsys.sv */
`default_nettype none
`include "mem_consts.svh"

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int W = `MEM_DATA_W;
    localparam int NC = `MEM_CLIENTS;
    localparam int WORDS = `MEM_DEPTH_WORDS;
    localparam int BYTES_TOTAL = WORDS * `MEM_BYTES;
    localparam int T5_LEN = 40; // accesses per client while both compete.
    localparam int ACCESSES = 3 * WORDS + 160 + 64 + NC * T5_LEN;
    localparam int WATCHDOG_CYCLES = ACCESSES * 12 + 500;

    logic            clk = 1'b0;
    logic            rst = 1'b1;
    logic [NC-1:0]   requests = '0;
    logic [NC*W-1:0] addrs = '0;
    logic [NC-1:0]   wes = '0;
    logic [2*NC-1:0] widths = '0;
    logic [NC*W-1:0] wdata = '0;
    logic [NC*W-1:0] rdata;
    logic [NC-1:0]   readies;

    logic [31:0] lfsr_q = 32'hb322;
    logic [7:0]  model [BYTES_TOTAL]; // mirrors the RAM byte by byte.
    int          served [$];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_base = 0;
    logic [31:0] t5_addr [NC][T5_LEN];
    logic [31:0] t5_data [NC][T5_LEN];
    logic [2:0]  t5_ctl [NC][T5_LEN]; // write flag above the width code.

    mem_subsys mem_subsys_inst (.*);

    always #5 clk = ~clk;

    // Galois LFSR stepped once for every bit handed out.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // an access that stays inside one word is ready in cycle 3, a split one in cycle 5.
    function automatic int expected_latency(input logic [31:0] addr, input mem_width_e w);
        if (w == ACC_8 || (w == ACC_16 && addr[1:0] != 2'd3) || addr[1:0] == 2'd0) begin
            return 3;
        end
        return 5;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr, input logic [1:0] width);
        logic [31:0] v;
        v = '0; // zero-extended little-endian bytes.
        for (int i = 0; i < (1 << width); i++) begin
            v[8*i +: 8] = model[(addr + 32'(i)) % BYTES_TOTAL];
        end
        return v;
    endfunction

    task automatic run_access(input int c, input logic [31:0] addr, input logic we,
                              input mem_width_e width, input logic [31:0] data,
                              input int exp_lat, input logic hold = 1'b0);
        int cycles;
        @(negedge clk);
        addrs[c*W +: W] = addr;
        wes[c] = we;
        widths[2*c +: 2] = width;
        wdata[c*W +: W] = data;
        requests[c] = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (readies[c] !== 1'b1 && cycles < 64);
        assert (readies[c] === 1'b1) else begin
            $display("client %0d got no ready within %0d cycles", c, cycles);
            errors++;
        end
        assert (exp_lat == 0 || cycles == exp_lat) else begin
            $display("Mismatch ready cycle at addr %h: got %h, expected %h", addr, cycles, exp_lat);
            errors++;
        end
        // a held request presents the next access in the cycle after ready.
        if (!hold) begin
            @(negedge clk);
            requests[c] = 1'b0;
        end
    endtask

    task automatic run_client(input int c);
        for (int i = 0; i < T5_LEN; i++) begin
            run_access(c, t5_addr[c][i], t5_ctl[c][i][2], mem_width_e'(t5_ctl[c][i][1:0]),
                       t5_data[c][i], 0, i < T5_LEN - 1);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        requests = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    always @(posedge clk) begin : compare_responses
        logic [31:0] addr_c;
        logic [31:0] exp_val;
        if (!rst && readies !== '0) begin
            assert ((readies & (readies - 1'b1)) == '0) else begin
                $display("more than one client saw ready in the same cycle");
                errors++;
            end
            for (int c = 0; c < NC; c++) begin
                addr_c = addrs[c*W +: W];
                if (readies[c] !== 1'b1) begin
                    assert (rdata[c*W +: W] === '0) else begin
                        $display("Mismatch rdata[%0d] without ready: got %h, expected %h",
                                 c, rdata[c*W +: W], 32'h0);
                        errors++;
                    end
                end else begin
                    served.push_back(c);
                    if (wes[c]) begin
                        for (int i = 0; i < (1 << widths[2*c +: 2]); i++) begin
                            model[(addr_c + 32'(i)) % BYTES_TOTAL] = wdata[c*W + 8*i +: 8];
                        end
                    end else begin
                        exp_val = ref_read(addr_c, widths[2*c +: 2]);
                        checks++;
                        assert (rdata[c*W +: W] === exp_val) else begin
                            $display("Mismatch rdata[%0d] at addr %h: got %h, expected %h",
                                     c, addr_c, rdata[c*W +: W], exp_val);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] base;
        logic [31:0] a;
        mem_width_e  w;
        int          t5_start;
        apply_reset();
        repeat (20) begin
            @(posedge clk);
            assert (readies === '0) else begin
                $display("Mismatch readies: got %h, expected %h", readies, 2'b00);
                errors++;
            end
        end
        finish_test("idle after reset");
        // the word writes also give every RAM byte a known value.
        for (int k = 0; k < WORDS; k++) begin
            run_access(0, 32'(k) << 2, 1'b1, ACC_32,
                       {8'(k), ~8'(k), 8'(k) ^ 8'h5a, 8'(k) + 8'h33}, 3);
        end
        for (int k = 0; k < WORDS; k++) begin
            run_access(0, 32'(k) << 2, 1'b0, ACC_32, '0, 3);
        end
        finish_test("aligned words");
        for (int k = 0; k < 40; k++) begin
            a = take_bits(12); // wider than the RAM, so some addresses wrap.
            w = take_bits(1) ? ACC_16 : ACC_8;
            run_access(0, a, 1'b1, w, take_bits(16), expected_latency(a, w));
            run_access(0, a & ~32'h3, 1'b0, ACC_32, '0, 3);
            run_access(0, a - 1, 1'b0, ACC_8, '0, 3);
            run_access(0, a + (w == ACC_16 ? 2 : 1), 1'b0, ACC_8, '0, 3);
        end
        finish_test("narrow writes");
        for (int r = 0; r < 4; r++) begin
            base = (r == 0) ? 32'(BYTES_TOTAL - 4) : take_bits(8) << 2; // the top word first.
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 2; k++) begin
                    w = k ? ACC_32 : ACC_16;
                    a = base + 32'(off);
                    run_access(0, a, 1'b1, w, take_bits(32), expected_latency(a, w));
                    run_access(0, a, 1'b0, w, '0, expected_latency(a, w));
                end
            end
        end
        finish_test("unaligned accesses");
        for (int c = 0; c < NC; c++) begin
            for (int i = 0; i < T5_LEN; i++) begin
                t5_addr[c][i] = take_bits(10);
                t5_ctl[c][i][2] = 1'(take_bits(1));
                t5_ctl[c][i][1:0] = 2'(take_bits(2) % 3);
                t5_data[c][i] = take_bits(32);
            end
        end
        apply_reset(); // the arbiter pointer restarts so client 0 wins first.
        t5_start = served.size();
        fork
            run_client(0);
            run_client(1);
        join
        for (int i = t5_start; i < served.size(); i++) begin
            assert (served[i] == (i - t5_start) % NC) else begin
                $display("Mismatch grant %0d: got client %h, expected %h",
                         i - t5_start, served[i], (i - t5_start) % NC);
                errors++;
            end
        end
        for (int k = 0; k < WORDS; k++) begin
            run_access(0, 32'(k) << 2, 1'b0, ACC_32, '0, 3);
        end
        finish_test("two clients");
        $display("%0d tests, %0d reads compared, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/mem_pkg.sv
hdl/byte_ram.sv
mem_if/mem_arbiter.sv
mem_if/mem_if.sv
hdl/mem_subsys.sv
bench/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

export_include_dirs:
  - common

sources:
  - common/mem_pkg.sv
  - hdl/byte_ram.sv
  - mem_if/mem_arbiter.sv
  - mem_if/mem_if.sv
  - hdl/mem_subsys.sv
  - target: simulation
    files:
      - bench/tb_mem_subsys.sv
